//--- pad_defines.svh
`ifndef PAD_DEFINES_SVH
`define PAD_DEFINES_SVH

// Pixel word width.
`define DATA_WIDTH 16

// Input frame geometry.
`define IMG_WIDTH  4
`define IMG_HEIGHT 3
`define CHANNELS   2

// Zero border thickness on each side.
`define PAD_WIDTH  2
`define PAD_HEIGHT 2

`define FRAME_WORDS (`IMG_WIDTH * `IMG_HEIGHT * `CHANNELS)
`define ADDR_WIDTH  $clog2(`FRAME_WORDS)

`endif

//--- pad_pkg.sv
`default_nettype none

`include "pad_defines.svh"

package pad_pkg;

  // One feature-map pixel.
  typedef logic [`DATA_WIDTH-1:0] pixel_t;

  // Word address inside one bank.
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // Request to the feature RAM, shared by writer and reader.
  typedef struct packed {
    logic   we;     // Write enable.
    logic   bank;   // Bank select.
    addr_t  addr;   // Word address in the bank.
    pixel_t wdata;  // Write data, unused on reads.
  } mem_req_t;

endpackage

`default_nettype wire

//--- skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
  parameter type payload_t = logic
) (
  input  wire      clk,
  input  wire      rst,
  input  payload_t in_data,
  input  wire      in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  wire      out_ready
);
  payload_t main_data;
  payload_t skid_data;
  logic     main_valid;
  logic     skid_valid;
  logic     stall;
  logic     take;

  assign in_ready  = !skid_valid;  // Registered, no path from out_ready.
  assign out_data  = main_data;
  assign out_valid = main_valid;
  assign stall     = main_valid && !out_ready;
  assign take      = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (!stall) begin
      main_valid <= skid_valid || take;  // Refill from skid first.
      skid_valid <= 1'b0;
    end else if (take) begin
      skid_valid <= 1'b1;  // Park the word while output is stuck.
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      main_data <= skid_valid ? skid_data : in_data;
    end else if (take) begin
      skid_data <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- feature_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "pad_defines.svh"

module feature_ram (
  input  wire                clk,
  input  pad_pkg::mem_req_t  req,
  input  wire                req_valid,
  output pad_pkg::pixel_t    rd_data
);
  // Two frame banks, one per buffering slot.
  pad_pkg::pixel_t mem [2][`FRAME_WORDS];

  always_ff @(posedge clk) begin
    if (req_valid) begin
      if (req.we) begin
        mem[req.bank][req.addr] <= req.wdata;
      end else begin
        rd_data <= mem[req.bank][req.addr];  // One cycle read latency.
      end
    end
  end

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire               clk,
  input  wire               rst,
  input  pad_pkg::mem_req_t a_req,
  input  wire               a_valid,
  output logic              a_ready,
  input  pad_pkg::mem_req_t b_req,
  input  wire               b_valid,
  output logic              b_ready,
  output pad_pkg::mem_req_t ram_req,
  output logic              ram_valid,
  output logic              rd_valid
);
  logic              last_b;       // Port b won the last grant.
  logic              grant_a;
  logic              grant_b;
  logic              slice_ready;
  pad_pkg::mem_req_t sel_req;

  assign grant_a = a_valid && (!b_valid || last_b);
  assign grant_b = b_valid && !grant_a;
  assign sel_req = grant_a ? a_req : b_req;
  assign a_ready = grant_a && slice_ready;
  assign b_ready = grant_b && slice_ready;

  skid_buffer #(
    .payload_t(pad_pkg::mem_req_t)
  ) req_slice (
    .clk      (clk),
    .rst      (rst),
    .in_data  (sel_req),
    .in_valid (a_valid || b_valid),
    .in_ready (slice_ready),
    .out_data (ram_req),
    .out_valid(ram_valid),
    .out_ready(1'b1)  // RAM takes a request every cycle.
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      last_b   <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      if ((a_valid || b_valid) && slice_ready) begin
        last_b <= grant_b;
      end
      rd_valid <= ram_valid && !ram_req.we;  // Read data lands next cycle.
    end
  end

endmodule

`default_nettype wire

//--- frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pad_defines.svh"

module frame_writer (
  input  wire               clk,
  input  wire               rst,
  input  pad_pkg::pixel_t   in_data,
  input  wire               in_valid,
  output logic              in_ready,
  output pad_pkg::mem_req_t req,
  output logic              req_valid,
  input  wire               req_ready,
  input  wire               bank_free,
  output logic              bank_full
);
  logic           active;     // Low during reset.
  logic           wr_bank;
  logic           free_ptr;   // Next bank the reader hands back.
  logic [1:0]     full;
  logic           req_last;
  pad_pkg::addr_t addr;
  logic           take;
  logic           last_word;

  assign in_ready  = active && !full[wr_bank] && (!req_valid || req_ready);
  assign take      = in_valid && in_ready;
  assign last_word = addr == `FRAME_WORDS - 1;

  always_ff @(posedge clk) begin
    if (rst) begin
      active    <= 1'b0;
      wr_bank   <= 1'b0;
      free_ptr  <= 1'b0;
      full      <= '0;
      addr      <= '0;
      req_valid <= 1'b0;
      bank_full <= 1'b0;
    end else begin
      active    <= 1'b1;
      bank_full <= req_valid && req_ready && req_last;  // Last write is queued.
      if (take || req_ready) begin
        req_valid <= take;
      end
      if (take) begin
        addr <= last_word ? '0 : addr + 1'b1;
        if (last_word) begin
          wr_bank <= !wr_bank;
        end
      end
      if (bank_free) begin
        full[free_ptr] <= 1'b0;
        free_ptr       <= !free_ptr;
      end
      if (take && last_word) begin
        full[wr_bank] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      req      <= '{we: 1'b1, bank: wr_bank, addr: addr, wdata: in_data};
      req_last <= last_word;
    end
  end

endmodule

`default_nettype wire

//--- frame_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "pad_defines.svh"

module frame_reader (
  input  wire               clk,
  input  wire               rst,
  input  wire               bank_full,
  output logic              bank_free,
  output pad_pkg::mem_req_t req,
  output logic              req_valid,
  input  wire               req_ready,
  input  wire               rd_valid,
  input  pad_pkg::pixel_t   rd_data,
  output pad_pkg::pixel_t   out_data,
  output logic              out_valid,
  input  wire               out_ready
);
  logic           rd_bank;     // Oldest filled bank.
  logic           in_flight;
  logic [1:0]     filled;      // Banks waiting to be drained.
  pad_pkg::addr_t rd_addr;
  logic           last_addr;
  logic           issue;
  logic           accept;
  logic           release_bank;

  assign req          = '{we: 1'b0, bank: rd_bank, addr: rd_addr, wdata: '0};
  assign last_addr    = rd_addr == `FRAME_WORDS - 1;
  assign accept       = req_valid && req_ready;
  assign release_bank = accept && last_addr;

  // One read at a time, and only when its return slot will be empty.
  assign issue = (filled != 2'd0) && !req_valid && !in_flight
               && (!out_valid || out_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_bank   <= 1'b0;
      in_flight <= 1'b0;
      filled    <= 2'd0;
      rd_addr   <= '0;
      req_valid <= 1'b0;
      out_valid <= 1'b0;
      bank_free <= 1'b0;
    end else begin
      bank_free <= release_bank;
      filled    <= filled + {1'b0, bank_full} - {1'b0, release_bank};
      if (issue) begin
        req_valid <= 1'b1;
      end else if (accept) begin
        req_valid <= 1'b0;
      end
      if (accept) begin
        in_flight <= 1'b1;
        rd_addr   <= last_addr ? '0 : rd_addr + 1'b1;
        if (last_addr) begin
          rd_bank <= !rd_bank;
        end
      end else if (rd_valid) begin
        in_flight <= 1'b0;
      end
      if (rd_valid) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      out_data <= rd_data;  // Held until padding takes it.
    end
  end

endmodule

`default_nettype wire

//--- zero_padding.sv
`timescale 1ns/1ps
`default_nettype none

`include "pad_defines.svh"

module zero_padding (
  input  wire             clk,
  input  wire             rst,
  input  pad_pkg::pixel_t in_data,
  input  wire             in_valid,
  output logic            in_ready,
  output pad_pkg::pixel_t out_data,
  output logic            out_valid,
  input  wire             out_ready
);
  localparam int COLS = `IMG_WIDTH + 2 * `PAD_WIDTH;
  localparam int ROWS = `IMG_HEIGHT + 2 * `PAD_HEIGHT;
  localparam int C_W  = $clog2(`CHANNELS + 1);
  localparam int X_W  = $clog2(COLS + 1);
  localparam int Y_W  = $clog2(ROWS + 1);

  pad_pkg::pixel_t buf_data;
  logic            buf_valid;
  logic            buf_ready;
  logic [C_W-1:0]  count_c;
  logic [X_W-1:0]  count_x;
  logic [Y_W-1:0]  count_y;
  logic            start;  // A frame is in progress.
  logic            in_take;
  logic            out_take;
  logic            last_c;
  logic            last_x;
  logic            last_y;
  logic            frame_end;
  logic            border;

  skid_buffer #(
    .payload_t(pad_pkg::pixel_t)
  ) in_slice (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_data (buf_data),
    .out_valid(buf_valid),
    .out_ready(buf_ready)
  );

  assign in_take   = in_valid && in_ready;
  assign out_take  = out_valid && out_ready;
  assign last_c    = count_c == `CHANNELS - 1;
  assign last_x    = count_x == COLS - 1;
  assign last_y    = count_y == ROWS - 1;
  assign frame_end = out_take && last_c && last_x && last_y;

  assign border = (count_x < `PAD_WIDTH) || (count_x >= `PAD_WIDTH + `IMG_WIDTH)
               || (count_y < `PAD_HEIGHT) || (count_y >= `PAD_HEIGHT + `IMG_HEIGHT);

  assign out_data  = border ? '0 : buf_data;
  assign out_valid = border ? start : buf_valid;
  assign buf_ready = border ? 1'b0 : out_ready;  // Hold input in the border.

  // A next-frame pixel already buffered keeps the frame running.
  always_ff @(posedge clk) begin
    if (rst) begin
      start <= 1'b0;
    end else if (frame_end) begin
      start <= in_take || buf_valid;
    end else if (in_take) begin
      start <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count_c <= '0;
      count_x <= '0;
      count_y <= '0;
    end else if (out_take) begin
      if (last_c) begin
        count_c <= '0;
        if (last_x) begin
          count_x <= '0;
          count_y <= last_y ? '0 : count_y + 1'b1;  // Wrap at frame end.
        end else begin
          count_x <= count_x + 1'b1;
        end
      end else begin
        count_c <= count_c + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- pad_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module pad_subsystem (
  input  wire             clk,
  input  wire             rst,
  input  pad_pkg::pixel_t in_data,
  input  wire             in_valid,
  output logic            in_ready,
  output pad_pkg::pixel_t out_data,
  output logic            out_valid,
  input  wire             out_ready
);
  pad_pkg::mem_req_t wr_req;
  pad_pkg::mem_req_t rd_req;
  pad_pkg::mem_req_t ram_req;
  logic              wr_req_valid;
  logic              wr_req_ready;
  logic              rd_req_valid;
  logic              rd_req_ready;
  logic              ram_valid;
  logic              rd_valid;
  logic              bank_full;
  logic              bank_free;
  pad_pkg::pixel_t   ram_rd_data;
  pad_pkg::pixel_t   pix_data;
  logic              pix_valid;
  logic              pix_ready;

  frame_writer frame_writer_inst (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .req      (wr_req),
    .req_valid(wr_req_valid),
    .req_ready(wr_req_ready),
    .bank_free(bank_free),
    .bank_full(bank_full)
  );

  frame_reader frame_reader_inst (
    .clk      (clk),
    .rst      (rst),
    .bank_full(bank_full),
    .bank_free(bank_free),
    .req      (rd_req),
    .req_valid(rd_req_valid),
    .req_ready(rd_req_ready),
    .rd_valid (rd_valid),
    .rd_data  (ram_rd_data),
    .out_data (pix_data),
    .out_valid(pix_valid),
    .out_ready(pix_ready)
  );

  mem_arbiter mem_arbiter_inst (
    .clk      (clk),
    .rst      (rst),
    .a_req    (wr_req),
    .a_valid  (wr_req_valid),
    .a_ready  (wr_req_ready),
    .b_req    (rd_req),
    .b_valid  (rd_req_valid),
    .b_ready  (rd_req_ready),
    .ram_req  (ram_req),
    .ram_valid(ram_valid),
    .rd_valid (rd_valid)
  );

  feature_ram feature_ram_inst (
    .clk      (clk),
    .req      (ram_req),
    .req_valid(ram_valid),
    .rd_data  (ram_rd_data)
  );

  zero_padding zero_padding_inst (
    .clk      (clk),
    .rst      (rst),
    .in_data  (pix_data),
    .in_valid (pix_valid),
    .in_ready (pix_ready),
    .out_data (out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

endmodule

`default_nettype wire

//--- tb_pad_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "pad_defines.svh"

module tb_pad_subsystem;
  localparam int COLS         = `IMG_WIDTH + 2 * `PAD_WIDTH;
  localparam int ROWS         = `IMG_HEIGHT + 2 * `PAD_HEIGHT;
  localparam int WAIT_LIMIT   = 200;   // Cycles for one handshake.
  localparam int DRAIN_LIMIT  = 4000;  // Cycles to empty the expected list.

  logic            clk;
  logic            rst;
  pad_pkg::pixel_t in_data;
  logic            in_valid;
  logic            in_ready;
  pad_pkg::pixel_t out_data;
  logic            out_valid;
  logic            out_ready;

  integer          seed;
  int              ready_mode;  // 0 high, 1 random, 2 low.
  int              err_count;
  int              test_errs;
  int              pass_count;
  int              fail_count;
  pad_pkg::pixel_t frame [`FRAME_WORDS];
  pad_pkg::pixel_t exp_q [$];

  pad_subsystem pad_subsystem_inst (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_data (out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Output back-pressure pattern.
  always @(posedge clk) begin
    #1;
    case (ready_mode)
      0:       out_ready = 1'b1;
      1:       out_ready = ($random(seed) & 3) != 0;  // Ready about 3 of 4 cycles.
      default: out_ready = 1'b0;
    endcase
  end

  // Expected padded frame from the rows, columns and channels.
  function automatic void pad_frame();
    int idx;
    idx = 0;
    for (int y = 0; y < ROWS; y++) begin
      for (int x = 0; x < COLS; x++) begin
        for (int c = 0; c < `CHANNELS; c++) begin
          if (x < `PAD_WIDTH || x >= `PAD_WIDTH + `IMG_WIDTH
              || y < `PAD_HEIGHT || y >= `PAD_HEIGHT + `IMG_HEIGHT) begin
            exp_q.push_back('0);
          end else begin
            exp_q.push_back(frame[idx]);
            idx++;
          end
        end
      end
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s got 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
    end
  endtask

  task automatic abort_run(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic finish_test(input string name);
    if (err_count == test_errs) begin
      pass_count++;
      $display("%s: passed", name);
    end else begin
      fail_count++;
      $display("%s: failed with %0d errors", name, err_count - test_errs);
    end
    test_errs = err_count;
  endtask

  task automatic wait_in_ready(input logic level, input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (in_ready !== level && cycles < WAIT_LIMIT);
    if (in_ready !== level) abort_run(what);
  endtask

  // Starts 1 ns after a rising edge and ends there too.
  task automatic send_frame();
    for (int i = 0; i < `FRAME_WORDS; i++) begin
      frame[i] = pad_pkg::pixel_t'($random(seed));
    end
    pad_frame();
    for (int i = 0; i < `FRAME_WORDS; i++) begin
      in_data  = frame[i];
      in_valid = 1'b1;  // Held with its data until accepted.
      wait_in_ready(1'b1, "input pixel was not accepted before the timeout");
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      abort_run("output stream stopped with expected words still pending");
    end else begin
      repeat (4) @(negedge clk);
      check_value("out_valid", out_valid, 1'b0);  // No extra words.
    end
  endtask

  // Compare each output transfer against the expected list.
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        err_count++;
        $display("ERROR at %0t: output word arrived with nothing expected", $time);
      end else begin
        check_value("out_data", out_data, exp_q.pop_front());
      end
    end
  end

  initial begin
    seed       = 62302;
    rst        = 1'b1;
    in_data    = '0;
    in_valid   = 1'b0;
    out_ready  = 1'b0;
    ready_mode = 0;
    err_count  = 0;
    test_errs  = 0;
    pass_count = 0;
    fail_count = 0;

    @(posedge clk);
    @(negedge clk);
    check_value("in_ready", in_ready, 1'b0);
    check_value("out_valid", out_valid, 1'b0);
    @(posedge clk);
    #1;
    rst = 1'b0;
    wait_in_ready(1'b1, "in_ready did not rise after reset was released");
    finish_test("reset");

    @(posedge clk);
    #1;
    send_frame();
    wait_drain();
    finish_test("single frame");

    ready_mode = 1;
    @(posedge clk);
    #1;
    send_frame();
    wait_drain();
    finish_test("random back-pressure");

    ready_mode = 0;
    @(posedge clk);
    #1;
    repeat (3) send_frame();
    wait_drain();
    finish_test("three frames back to back");

    ready_mode = 2;
    @(posedge clk);
    #1;
    repeat (2) send_frame();
    wait_in_ready(1'b0, "in_ready stayed high with both banks full");
    repeat (40) @(negedge clk);
    check_value("in_ready", in_ready, 1'b0);  // Both banks still held.
    ready_mode = 0;
    wait_drain();
    finish_test("stall and drain");

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
pad_pkg.sv
skid_buffer.sv
feature_ram.sv
mem_arbiter.sv
frame_writer.sv
frame_reader.sv
zero_padding.sv
pad_subsystem.sv
tb_pad_subsystem.sv

//--- Bender.yml
package:
  name: pad_subsystem

sources:
  - include_dirs:
      - .
    files:
      - pad_pkg.sv
      - skid_buffer.sv
      - feature_ram.sv
      - mem_arbiter.sv
      - frame_writer.sv
      - frame_reader.sv
      - zero_padding.sv
      - pad_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pad_subsystem.sv
